// ==== src/icache_ctrl_pkg.sv ====
/*
 * Shared definitions of the instruction-cache control unit.
 * Holds the register map of the peripheral slave port, the bus widths,
 * the request and response structs of that port and the operation codes
 * that the register block hands to the sequencer.
 */
`default_nettype none

package icache_ctrl_pkg;

   localparam int unsigned DataWidth = 32;   // Peripheral data and address
   localparam int unsigned IdWidth   = 5;    // Requester ID

   // Byte offsets, decoded from addr[7:0]
   localparam logic [7:0] RegEnable   = 8'h00;
   localparam logic [7:0] RegFlush    = 8'h04;
   localparam logic [7:0] RegFlushL1  = 8'h08;
   localparam logic [7:0] RegSelFlush = 8'h0C;
   localparam logic [7:0] RegPrefetch = 8'h18;

   localparam logic [DataWidth-1:0] UnmappedData = 32'hDEAD_CA5E;

   typedef struct packed {
      logic                 req;
      logic [DataWidth-1:0] addr;
      logic                 wen;     // High for a read
      logic [DataWidth-1:0] wdata;
      logic [IdWidth-1:0]   id;
   } periph_req_t;

   typedef struct packed {
      logic                 gnt;
      logic                 r_valid;
      logic                 r_opc;   // Always zero
      logic [IdWidth-1:0]   r_id;
      logic [DataWidth-1:0] r_rdata;
   } periph_rsp_t;

   // Operations run by the sequencer
   typedef enum logic [2:0] {
      OP_NONE,
      OP_ENABLE,
      OP_DISABLE,
      OP_FLUSH,
      OP_FLUSH_L1,
      OP_SEL_FLUSH
   } op_e;

endpackage

`default_nettype wire

// ==== src/ack_tracker.sv ====
/*
 * Four-phase request fan-out to a group of N caches.
 * On start every selected target gets a request, which drops once its ack
 * is seen; the target is released when its ack falls again. Done is high
 * while nothing is pending and all acks are low.
 */
`timescale 1ns/1ns
`default_nettype none

module ack_tracker #(
   parameter int unsigned N = 4
) (
   input  wire logic         clk_i,
   input  wire logic         rst_ni,
   input  wire logic         start_i,
   input  wire logic [N-1:0] sel_i,
   input  wire logic [N-1:0] ack_i,
   output logic [N-1:0]      req_o,
   output logic              done_o
);

   logic [N-1:0] pending_q;   // Handshake open for this target
   logic [N-1:0] acked_q;     // Ack seen, waiting for it to fall
   logic [N-1:0] seen;
   logic [N-1:0] released;

   assign seen     = req_o & ack_i;
   assign released = acked_q & ~ack_i;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pending_q <= '0;
         acked_q   <= '0;
      end else if (start_i) begin
         pending_q <= sel_i;         // Unselected targets stay quiet
         acked_q   <= '0;
      end else begin
         pending_q <= pending_q & ~released;
         acked_q   <= (acked_q | seen) & ~released;
      end
   end

   assign req_o  = pending_q & ~acked_q;
   assign done_o = ~|pending_q & ~|req_o & ~|ack_i;

endmodule

`default_nettype wire

// ==== src/icache_ctrl_seq.sv ====
/*
 * Operation sequencer of the cache control unit.
 * Takes one operation from the register block, launches the flush or
 * selective-flush trackers or waits for the caches to settle on a new
 * enable level, and pulses done once everything has completed. Busy holds
 * off the peripheral grant for the whole operation.
 */
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl_seq (
   input  wire logic                 clk_i,
   input  wire logic                 rst_ni,
   input  wire icache_ctrl_pkg::op_e op_i,
   input  wire logic                 start_i,
   output logic                      busy_o,
   output logic                      done_o,
   output logic                      flush_start_o,
   output logic                      sel_start_o,
   input  wire logic                 flush_done_i,   // L1 and L2 trackers both done
   input  wire logic                 sel_done_i,
   input  wire logic                 level_ok_i
);
   import icache_ctrl_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_WAIT_LEVEL,
      S_WAIT_FLUSH,
      S_WAIT_SEL
   } state_e;

   state_e state_q;
   state_e state_d;
   logic   done_d;
   logic   flush_launch;
   logic   sel_launch;

   always_comb begin
      state_d = state_q;
      done_d  = 1'b0;

      case (state_q)
         S_IDLE: begin
            if (start_i) begin
               case (op_i)
                  OP_ENABLE, OP_DISABLE:  state_d = S_WAIT_LEVEL;
                  OP_FLUSH, OP_FLUSH_L1:  state_d = S_WAIT_FLUSH;
                  OP_SEL_FLUSH:           state_d = S_WAIT_SEL;
                  default:                state_d = S_IDLE;
               endcase
            end
         end

         // Enable register is already updated here
         S_WAIT_LEVEL: begin
            if (level_ok_i) begin
               state_d = S_IDLE;
               done_d  = 1'b1;
            end
         end

         // Tracker still reports idle in its start cycle
         S_WAIT_FLUSH: begin
            if (flush_done_i && !flush_start_o) begin
               state_d = S_IDLE;
               done_d  = 1'b1;
            end
         end

         S_WAIT_SEL: begin
            if (sel_done_i && !sel_start_o) begin
               state_d = S_IDLE;
               done_d  = 1'b1;
            end
         end

         default: state_d = S_IDLE;
      endcase
   end

   // Launch one cycle after start so the trackers see the new selects
   assign flush_launch = (state_q == S_IDLE) && (state_d == S_WAIT_FLUSH);
   assign sel_launch   = (state_q == S_IDLE) && (state_d == S_WAIT_SEL);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q       <= S_IDLE;
         done_o        <= 1'b0;
         flush_start_o <= 1'b0;
         sel_start_o   <= 1'b0;
      end else begin
         state_q       <= state_d;
         done_o        <= done_d;
         flush_start_o <= flush_launch;
         sel_start_o   <= sel_launch;
      end
   end

   // Busy also covers the done cycle before the response
   assign busy_o = (state_q != S_IDLE) || done_o;

endmodule

`default_nettype wire

// ==== src/icache_ctrl_regs.sv ====
/*
 * Register block behind the peripheral slave port.
 * Accepts requests while the sequencer is idle, holds the enable, flush,
 * selective-flush address and prefetch registers, turns control writes
 * into a sequencer operation and returns one tagged response per access.
 */
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl_regs #(
   parameter int unsigned NbCores = 9,
   parameter int unsigned NbBanks = 4
) (
   input  wire logic                             clk_i,
   input  wire logic                             rst_ni,
   input  wire icache_ctrl_pkg::periph_req_t     periph_req_i,
   output icache_ctrl_pkg::periph_rsp_t          periph_rsp_o,
   input  wire logic                             busy_i,
   input  wire logic                             done_i,
   output icache_ctrl_pkg::op_e                  op_o,
   output logic                                  start_o,
   output logic [NbCores+NbBanks-1:0]            flush_sel_o,
   output logic [NbCores+NbBanks-1:0]            enable_o,
   output logic [icache_ctrl_pkg::DataWidth-1:0] sel_flush_addr_o,
   output logic [NbCores-1:0]                    prefetch_en_o
);
   import icache_ctrl_pkg::*;

   localparam int unsigned NbCaches = NbCores + NbBanks;

   logic                 accept;
   logic                 rd_en;
   logic                 wr_en;
   logic                 rsp_now;     // Answer in the next cycle
   logic [7:0]           offset;
   logic                 wbit;
   logic [NbCaches-1:0]  enable_q;
   logic [NbCaches-1:0]  flush_q;
   logic [DataWidth-1:0] sel_addr_q;
   logic [NbCores-1:0]   prefetch_q;
   logic [DataWidth-1:0] rdata_d;
   logic                 r_valid_q;
   logic [IdWidth-1:0]   r_id_q;
   logic [DataWidth-1:0] r_rdata_q;

   assign accept = periph_req_i.req & ~busy_i;
   assign rd_en  = accept & periph_req_i.wen;
   assign wr_en  = accept & ~periph_req_i.wen;
   assign offset = periph_req_i.addr[7:0];
   assign wbit   = periph_req_i.wdata[0];

   // Writes that need the caches to take part
   always_comb begin
      op_o = OP_NONE;
      case (offset)
         RegEnable: begin
            if (wbit != enable_q[0]) begin   // Same level is already acked
               op_o = wbit ? OP_ENABLE : OP_DISABLE;
            end
         end
         RegFlush:    op_o = wbit ? OP_FLUSH : OP_NONE;
         RegFlushL1:  op_o = wbit ? OP_FLUSH_L1 : OP_NONE;
         RegSelFlush: op_o = OP_SEL_FLUSH;
         default:     op_o = OP_NONE;
      endcase
   end

   assign start_o = wr_en & (op_o != OP_NONE);
   assign rsp_now = rd_en | (wr_en & (op_o == OP_NONE));

   always_comb begin
      case (offset)
         RegEnable:            rdata_d = DataWidth'(enable_q);
         RegFlush, RegFlushL1: rdata_d = DataWidth'(flush_q);
         RegSelFlush:          rdata_d = sel_addr_q;
         RegPrefetch:          rdata_d = DataWidth'(prefetch_q);
         default:              rdata_d = UnmappedData;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         enable_q   <= '0;        // Caches start disabled
         flush_q    <= '0;
         sel_addr_q <= '0;
         prefetch_q <= '0;
         r_valid_q  <= 1'b0;
      end else begin
         r_valid_q <= rsp_now | done_i;
         if (done_i) begin
            flush_q <= '0;
         end
         if (wr_en) begin
            case (offset)
               RegEnable:   enable_q   <= {NbCaches{wbit}};
               RegFlush:    flush_q    <= {NbCaches{wbit}};
               RegFlushL1:  flush_q    <= {{NbBanks{1'b0}}, {NbCores{wbit}}};
               RegSelFlush: sel_addr_q <= periph_req_i.wdata;
               RegPrefetch: prefetch_q <= periph_req_i.wdata[NbCores-1:0];
               default:     ;
            endcase
         end
      end
   end

   // ID held until the matching response, even for long operations
   always_ff @(posedge clk_i) begin
      if (accept) begin
         r_id_q <= periph_req_i.id;
      end
      if (rsp_now | done_i) begin
         r_rdata_q <= rd_en ? rdata_d : '0;
      end
   end

   assign flush_sel_o      = flush_q;
   assign enable_o         = enable_q;
   assign sel_flush_addr_o = sel_addr_q;
   assign prefetch_en_o    = prefetch_q;

   always_comb begin
      periph_rsp_o.gnt     = ~busy_i;
      periph_rsp_o.r_valid = r_valid_q;
      periph_rsp_o.r_opc   = 1'b0;
      periph_rsp_o.r_id    = r_id_q;
      periph_rsp_o.r_rdata = r_rdata_q;
   end

endmodule

`default_nettype wire

// ==== src/icache_ctrl_top.sv ====
/*
 * Instruction-cache control unit for a multi-core cluster.
 * Software on the peripheral port enables or disables all caches, flushes
 * them fully or per address and sets the L1 prefetch mask. The register
 * block decodes the port, the sequencer runs one operation at a time and
 * four trackers run the flush handshakes towards the L1 and L2 caches.
 */
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl_top #(
   parameter int unsigned NbCores = 9,
   parameter int unsigned NbBanks = 4
) (
   input  wire logic                             clk_i,
   input  wire logic                             rst_ni,

   input  wire icache_ctrl_pkg::periph_req_t     periph_req_i,
   output icache_ctrl_pkg::periph_rsp_t          periph_rsp_o,

   output logic [NbCores-1:0]                    l1_bypass_o,
   input  wire logic [NbCores-1:0]               l1_bypass_ack_i,
   output logic [NbCores-1:0]                    l1_flush_req_o,
   input  wire logic [NbCores-1:0]               l1_flush_ack_i,
   output logic [NbCores-1:0]                    l1_sel_flush_req_o,
   input  wire logic [NbCores-1:0]               l1_sel_flush_ack_i,

   output logic [NbBanks-1:0]                    l2_enable_o,
   input  wire logic [NbBanks-1:0]               l2_enable_ack_i,
   output logic [NbBanks-1:0]                    l2_flush_req_o,
   input  wire logic [NbBanks-1:0]               l2_flush_ack_i,
   output logic [NbBanks-1:0]                    l2_sel_flush_req_o,
   input  wire logic [NbBanks-1:0]               l2_sel_flush_ack_i,

   output logic [icache_ctrl_pkg::DataWidth-1:0] sel_flush_addr_o,
   output logic [NbCores-1:0]                    prefetch_en_o
);
   import icache_ctrl_pkg::*;

   localparam int unsigned NbCaches = NbCores + NbBanks;

   op_e                 op;
   logic                start;
   logic                busy;
   logic                done;
   logic                flush_start;
   logic                sel_start;
   logic                level_ok;
   logic [NbCaches-1:0] flush_sel;     // Cores in the low bits, banks above
   logic [NbCaches-1:0] enable;
   logic                l1_flush_done;
   logic                l2_flush_done;
   logic                l1_sel_done;
   logic                l2_sel_done;

   assign l1_bypass_o = ~enable[NbCores-1:0];
   assign l2_enable_o = enable[NbCaches-1:NbCores];

   // Every cache has settled on its requested level
   assign level_ok = (l1_bypass_ack_i == l1_bypass_o) && (l2_enable_ack_i == l2_enable_o);

   icache_ctrl_regs #(
      .NbCores (NbCores),
      .NbBanks (NbBanks)
   ) icache_ctrl_regs_inst (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .periph_req_i     (periph_req_i),
      .periph_rsp_o     (periph_rsp_o),
      .busy_i           (busy),
      .done_i           (done),
      .op_o             (op),
      .start_o          (start),
      .flush_sel_o      (flush_sel),
      .enable_o         (enable),
      .sel_flush_addr_o (sel_flush_addr_o),
      .prefetch_en_o    (prefetch_en_o)
   );

   icache_ctrl_seq icache_ctrl_seq_inst (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .op_i          (op),
      .start_i       (start),
      .busy_o        (busy),
      .done_o        (done),
      .flush_start_o (flush_start),
      .sel_start_o   (sel_start),
      .flush_done_i  (l1_flush_done & l2_flush_done),
      .sel_done_i    (l1_sel_done & l2_sel_done),
      .level_ok_i    (level_ok)
   );

   ack_tracker #(.N(NbCores)) l1_flush_tracker_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .start_i (flush_start),
      .sel_i   (flush_sel[NbCores-1:0]),
      .ack_i   (l1_flush_ack_i),
      .req_o   (l1_flush_req_o),
      .done_o  (l1_flush_done)
   );

   ack_tracker #(.N(NbBanks)) l2_flush_tracker_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .start_i (flush_start),
      .sel_i   (flush_sel[NbCaches-1:NbCores]),    // Zero for an L1-only flush
      .ack_i   (l2_flush_ack_i),
      .req_o   (l2_flush_req_o),
      .done_o  (l2_flush_done)
   );

   ack_tracker #(.N(NbCores)) l1_sel_tracker_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .start_i (sel_start),
      .sel_i   ({NbCores{1'b1}}),
      .ack_i   (l1_sel_flush_ack_i),
      .req_o   (l1_sel_flush_req_o),
      .done_o  (l1_sel_done)
   );

   ack_tracker #(.N(NbBanks)) l2_sel_tracker_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .start_i (sel_start),
      .sel_i   ({NbBanks{1'b1}}),
      .ack_i   (l2_sel_flush_ack_i),
      .req_o   (l2_sel_flush_req_o),
      .done_o  (l2_sel_done)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
/*
 * Clock and reset source for the testbench.
 * Runs a free clock of the given period and holds the active-low reset
 * for a number of cycles, releasing it on a falling edge.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
   parameter int unsigned Period      = 10,
   parameter int unsigned ResetCycles = 2
) (
   output logic clk_o,
   output logic rst_no
);

   initial begin
      clk_o = 1'b0;
      forever #(Period / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_no = 1'b0;
      repeat (ResetCycles) @(posedge clk_o);
      @(negedge clk_o);
      rst_no = 1'b1;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_cache_model.sv ====
/*
 * Behavioral group of N caches on the control unit's side.
 * Each cache follows its enable level and answers flush and selective
 * flush requests with a four-phase ack after a random delay of 0 to 7
 * cycles. Rising edges of the flush requests are counted per cache.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_cache_model #(
   parameter int unsigned N         = 4,
   parameter logic        LevelInit = 1'b0
) (
   input  wire logic         clk_i,
   input  wire logic         rst_ni,
   input  wire logic [N-1:0] level_i,
   output logic [N-1:0]      level_ack_o,
   input  wire logic [N-1:0] flush_req_i,
   output logic [N-1:0]      flush_ack_o,
   input  wire logic [N-1:0] sel_req_i,
   output logic [N-1:0]      sel_ack_o,
   output logic [N-1:0][7:0] flush_pulses_o,
   output logic [N-1:0][7:0] sel_pulses_o
);
   localparam logic [31:0] Seed = 32'h792d_1be6;

   logic [31:0]       rnd;
   logic [N-1:0][2:0] level_wait;
   logic [N-1:0][2:0] flush_wait;
   logic [N-1:0][2:0] sel_wait;
   logic [N-1:0]      flush_req_q;
   logic [N-1:0]      sel_req_q;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Ack follows the request once the delay has run out
   function automatic logic [3:0] follow(input logic ack, input logic req,
                                         input logic [2:0] wait_cnt, input logic [2:0] delay);
      if (ack == req) begin
         return {ack, delay};      // Settled so the next delay is armed
      end
      if (wait_cnt == 3'd0) begin
         return {req, delay};
      end
      return {ack, wait_cnt - 3'd1};
   endfunction

   initial begin
      rnd          = Seed;
      level_ack_o <= {N{LevelInit}};
      flush_ack_o <= '0;
      sel_ack_o   <= '0;
   end

   // Acks are DUT inputs and change on the falling edge
   always @(negedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rnd = Seed;
         level_ack_o    <= {N{LevelInit}};
         flush_ack_o    <= '0;
         sel_ack_o      <= '0;
         level_wait     <= '0;
         flush_wait     <= '0;
         sel_wait       <= '0;
         flush_req_q    <= '0;
         sel_req_q      <= '0;
         flush_pulses_o <= '0;
         sel_pulses_o   <= '0;
      end else begin
         for (int i = 0; i < N; i++) begin
            rnd = xorshift(rnd);
            {level_ack_o[i], level_wait[i]} <=
               follow(level_ack_o[i], level_i[i], level_wait[i], rnd[2:0]);
            rnd = xorshift(rnd);
            {flush_ack_o[i], flush_wait[i]} <=
               follow(flush_ack_o[i], flush_req_i[i], flush_wait[i], rnd[2:0]);
            rnd = xorshift(rnd);
            {sel_ack_o[i], sel_wait[i]} <=
               follow(sel_ack_o[i], sel_req_i[i], sel_wait[i], rnd[2:0]);
            if (flush_req_i[i] && !flush_req_q[i]) begin
               flush_pulses_o[i] <= flush_pulses_o[i] + 8'd1;
            end
            if (sel_req_i[i] && !sel_req_q[i]) begin
               sel_pulses_o[i] <= sel_pulses_o[i] + 8'd1;
            end
         end
         flush_req_q <= flush_req_i;
         sel_req_q   <= sel_req_i;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_icache_ctrl.sv ====
/*
 * Testbench of the instruction-cache control unit.
 * Drives the peripheral port on falling edges through reset, enable,
 * flush, selective flush and prefetch accesses against two cache models.
 * Concurrent assertions watch the response protocol and the four-phase
 * flush handshakes, immediate assertions check read data and outputs.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_icache_ctrl;
   import icache_ctrl_pkg::*;

   localparam int unsigned NbCores     = 9;
   localparam int unsigned NbBanks     = 4;
   localparam int unsigned NbCaches    = NbCores + NbBanks;
   localparam int unsigned NumOps      = 17;    // Accesses issued below
   localparam int unsigned CyclesPerOp = 200;

   logic clk;
   logic rst_n;

   periph_req_t          preq;
   periph_rsp_t          prsp;
   logic [NbCores-1:0]   l1_bypass, l1_bypass_ack, l1_flush_req, l1_flush_ack;
   logic [NbCores-1:0]   l1_sel_req, l1_sel_ack, prefetch_en;
   logic [NbBanks-1:0]   l2_enable, l2_enable_ack, l2_flush_req, l2_flush_ack;
   logic [NbBanks-1:0]   l2_sel_req, l2_sel_ack;
   logic [DataWidth-1:0] sel_addr;

   logic [NbCores-1:0][7:0] l1_flush_cnt, l1_sel_cnt, l1_flush_base, l1_sel_base;
   logic [NbBanks-1:0][7:0] l2_flush_cnt, l2_sel_cnt, l2_flush_base, l2_sel_base;

   logic [2*NbCaches-1:0] all_req;
   logic [2*NbCaches-1:0] all_ack;
   logic                  accepted;
   int unsigned           outstanding;   // Accepted but not yet answered
   logic [IdWidth-1:0]    expected_id;
   logic [IdWidth-1:0]    next_id;

   tb_clk_gen #(.Period(10), .ResetCycles(2)) clk_gen_inst (
      .clk_o  (clk),
      .rst_no (rst_n)
   );

   icache_ctrl_top #(
      .NbCores (NbCores),
      .NbBanks (NbBanks)
   ) icache_ctrl_top_inst (
      .clk_i              (clk),
      .rst_ni             (rst_n),
      .periph_req_i       (preq),
      .periph_rsp_o       (prsp),
      .l1_bypass_o        (l1_bypass),
      .l1_bypass_ack_i    (l1_bypass_ack),
      .l1_flush_req_o     (l1_flush_req),
      .l1_flush_ack_i     (l1_flush_ack),
      .l1_sel_flush_req_o (l1_sel_req),
      .l1_sel_flush_ack_i (l1_sel_ack),
      .l2_enable_o        (l2_enable),
      .l2_enable_ack_i    (l2_enable_ack),
      .l2_flush_req_o     (l2_flush_req),
      .l2_flush_ack_i     (l2_flush_ack),
      .l2_sel_flush_req_o (l2_sel_req),
      .l2_sel_flush_ack_i (l2_sel_ack),
      .sel_flush_addr_o   (sel_addr),
      .prefetch_en_o      (prefetch_en)
   );

   tb_cache_model #(.N(NbCores), .LevelInit(1'b1)) l1_model_inst (
      .clk_i          (clk),
      .rst_ni         (rst_n),
      .level_i        (l1_bypass),
      .level_ack_o    (l1_bypass_ack),
      .flush_req_i    (l1_flush_req),
      .flush_ack_o    (l1_flush_ack),
      .sel_req_i      (l1_sel_req),
      .sel_ack_o      (l1_sel_ack),
      .flush_pulses_o (l1_flush_cnt),
      .sel_pulses_o   (l1_sel_cnt)
   );

   tb_cache_model #(.N(NbBanks), .LevelInit(1'b0)) l2_model_inst (
      .clk_i          (clk),
      .rst_ni         (rst_n),
      .level_i        (l2_enable),
      .level_ack_o    (l2_enable_ack),
      .flush_req_i    (l2_flush_req),
      .flush_ack_o    (l2_flush_ack),
      .sel_req_i      (l2_sel_req),
      .sel_ack_o      (l2_sel_ack),
      .flush_pulses_o (l2_flush_cnt),
      .sel_pulses_o   (l2_sel_cnt)
   );

   task automatic report_failure(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first failing check");
   endtask

   assign accepted = preq.req & prsp.gnt;
   assign all_req  = {l2_sel_req, l1_sel_req, l2_flush_req, l1_flush_req};
   assign all_ack  = {l2_sel_ack, l1_sel_ack, l2_flush_ack, l1_flush_ack};

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         outstanding <= 0;
         expected_id <= '0;
      end else begin
         if (accepted) begin
            expected_id <= preq.id;
         end
         outstanding <= outstanding + 32'(accepted) - 32'(prsp.r_valid);
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) prsp.r_valid |-> outstanding == 1)
      else report_failure("r_valid without exactly one open request");
   assert property (@(posedge clk) disable iff (!rst_n) prsp.r_valid |-> prsp.r_id == expected_id)
      else report_failure($sformatf("r_id %0d, expected %0d", prsp.r_id, expected_id));
   assert property (@(posedge clk) disable iff (!rst_n) prsp.r_valid |-> !prsp.r_opc)
      else report_failure("r_opc set on a response");
   assert property (@(posedge clk) disable iff (!rst_n)
                    (outstanding != 0 && !prsp.r_valid) |-> !prsp.gnt)
      else report_failure("gnt high while an operation is still running");
   // A request may only rise once its previous ack has fallen
   assert property (@(posedge clk) disable iff (!rst_n)
                    (all_req & ~$past(all_req) & $past(all_ack)) == '0)
      else report_failure("flush request rose while its ack was still high");

   task automatic access(input logic wen, input logic [7:0] offset,
                         input logic [DataWidth-1:0] wdata, input logic at_once,
                         output logic [DataWidth-1:0] rdata);
      @(negedge clk);
      preq.req   = 1'b1;
      preq.wen   = wen;
      preq.addr  = {24'h1A1040, offset};
      preq.wdata = wdata;
      preq.id    = next_id;
      next_id    = next_id + 5'd1;
      while (!prsp.gnt) @(negedge clk);
      @(negedge clk);                      // Accepted on the edge before
      preq.req = 1'b0;
      assert (prsp.r_valid == at_once)
         else report_failure($sformatf("r_valid %b one cycle after acceptance, expected %b",
                                       prsp.r_valid, at_once));
      while (!prsp.r_valid) @(negedge clk);
      rdata = prsp.r_rdata;
   endtask

   task automatic read_reg(input logic [7:0] offset, output logic [DataWidth-1:0] rdata);
      access(1'b1, offset, '0, 1'b1, rdata);
   endtask

   task automatic write_reg(input logic [7:0] offset, input logic [DataWidth-1:0] wdata,
                            input logic at_once);
      logic [DataWidth-1:0] unused;
      access(1'b0, offset, wdata, at_once, unused);
   endtask

   task automatic take_snapshot();
      l1_flush_base = l1_flush_cnt;
      l1_sel_base   = l1_sel_cnt;
      l2_flush_base = l2_flush_cnt;
      l2_sel_base   = l2_sel_cnt;
   endtask

   // Pulses per cache since the last snapshot
   task automatic check_pulses(input logic [7:0] l1_flush, input logic [7:0] l2_flush,
                               input logic [7:0] sel);
      for (int i = 0; i < NbCores; i++) begin
         assert (8'(l1_flush_cnt[i] - l1_flush_base[i]) == l1_flush &&
                 8'(l1_sel_cnt[i] - l1_sel_base[i]) == sel)
            else report_failure($sformatf("core %0d saw wrong number of flush pulses", i));
      end
      for (int i = 0; i < NbBanks; i++) begin
         assert (8'(l2_flush_cnt[i] - l2_flush_base[i]) == l2_flush &&
                 8'(l2_sel_cnt[i] - l2_sel_base[i]) == sel)
            else report_failure($sformatf("bank %0d saw wrong number of flush pulses", i));
      end
      assert (all_req == '0) else report_failure("flush request still high after response");
   endtask

   // Enable register image with one bit per cache
   function automatic logic [DataWidth-1:0] level_word(input logic on);
      logic [DataWidth-1:0] w;
      w = '0;
      w[NbCaches-1:0] = {NbCaches{on}};
      return w;
   endfunction

   initial begin
      repeat (NumOps * CyclesPerOp) @(posedge clk);
      $display("Watchdog expired after %0d cycles, an operation never completed",
               NumOps * CyclesPerOp);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation timed out");
   end

   initial begin
      logic [DataWidth-1:0] rdata;
      logic [DataWidth-1:0] mask;
      preq    = '0;
      next_id = 5'd3;
      @(posedge rst_n);
      @(negedge clk);

      assert (l1_bypass == '1 && l2_enable == '0) else report_failure("caches enabled at reset");
      assert (all_req == '0) else report_failure("flush request high at reset");
      read_reg(RegEnable, rdata);
      assert (rdata == '0) else report_failure($sformatf("RegEnable read %h after reset", rdata));
      read_reg(8'h40, rdata);
      assert (rdata == UnmappedData)
         else report_failure($sformatf("unmapped read %h, expected %h", rdata, UnmappedData));
      write_reg(8'h44, 32'h1234_5678, 1'b1);

      write_reg(RegEnable, 32'h1, 1'b0);
      assert (l1_bypass == '0 && l2_enable == '1) else report_failure("enable levels wrong");
      assert (l1_bypass_ack == '0 && l2_enable_ack == '1)
         else report_failure("enable answered before every cache acked");
      read_reg(RegEnable, rdata);
      assert (rdata == level_word(1'b1))
         else report_failure($sformatf("RegEnable read %h, expected %h", rdata, level_word(1'b1)));
      write_reg(RegEnable, 32'h1, 1'b1);   // Level already held
      write_reg(RegEnable, 32'h0, 1'b0);
      assert (l1_bypass_ack == '1 && l2_enable_ack == '0)
         else report_failure("disable answered before every cache acked");
      read_reg(RegEnable, rdata);
      assert (rdata == level_word(1'b0)) else report_failure($sformatf("RegEnable read %h", rdata));

      take_snapshot();
      write_reg(RegFlush, 32'h1, 1'b0);
      check_pulses(8'd1, 8'd1, 8'd0);
      read_reg(RegFlush, rdata);
      assert (rdata == '0) else report_failure($sformatf("RegFlush read %h after flush", rdata));
      take_snapshot();
      write_reg(RegFlushL1, 32'h1, 1'b0);
      check_pulses(8'd1, 8'd0, 8'd0);
      read_reg(RegFlushL1, rdata);
      assert (rdata == '0) else report_failure($sformatf("RegFlushL1 read %h", rdata));
      take_snapshot();
      write_reg(RegFlush, 32'h0, 1'b1);    // Bit 0 clear starts nothing
      check_pulses(8'd0, 8'd0, 8'd0);

      take_snapshot();
      write_reg(RegSelFlush, 32'h1C00_8A40, 1'b0);
      check_pulses(8'd0, 8'd0, 8'd1);
      assert (sel_addr == 32'h1C00_8A40) else report_failure($sformatf("sel addr %h", sel_addr));
      read_reg(RegSelFlush, rdata);
      assert (rdata == 32'h1C00_8A40) else report_failure($sformatf("RegSelFlush read %h", rdata));

      mask = 32'hA5A5_A55A;
      write_reg(RegPrefetch, mask, 1'b1);
      assert (prefetch_en == mask[NbCores-1:0])
         else report_failure($sformatf("prefetch_en %h", prefetch_en));
      read_reg(RegPrefetch, rdata);
      assert (rdata == DataWidth'(mask[NbCores-1:0]))
         else report_failure($sformatf("RegPrefetch read %h", rdata));

      @(negedge clk);
      if (outstanding == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         report_failure("request left without a response");
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
src/icache_ctrl_pkg.sv
src/ack_tracker.sv
src/icache_ctrl_seq.sv
src/icache_ctrl_regs.sv
src/icache_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_cache_model.sv
testbench/tb_icache_ctrl.sv

// ==== Makefile ====
# Verilator flow for the instruction-cache control unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_icache_ctrl

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_icache_ctrl \
		-o tb_icache_ctrl
	./obj_dir/tb_icache_ctrl | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
